// ==== src/serial_pkg.sv ====
package serial_pkg;

	// host transaction opcodes
	typedef enum logic [0:0] {
		op_write = 1'b0,
		op_read  = 1'b1
	} t_opcode;

	// serial engine states
	typedef enum logic [1:0] {
		// idle, waiting for a word
		Ready    = 2'd0,
		// shifting a word
		Transmit = 2'd1,
		// idle serial periods after a transaction
		Gap      = 2'd2
	} t_serial_state;

	// tag bits sit above the data bits of a fifo word
	localparam int TAG_BITS = 2;

	// final word of a transaction, gap follows
	localparam int TAG_LAST = 0;

	// received bits of this word go to the host
	localparam int TAG_CAPTURE = 1;

	// top bit of the address word
	// read uses this value, write the inverse
	localparam logic RW_BIT_READ = 1'b1;

endpackage

// ==== src/clkgen.sv ====
`timescale 1ns/10ps

module clkgen
#(
	// clock frequencies
	parameter int MAIN_CLK_HZ   = 10_000_000,
	parameter int SERIAL_CLK_HZ = 1_250_000
)
(
	input  logic in_clk,
	input  logic in_rst,

	// one-cycle edge enables for the serial engine
	output logic tick_fall,
	output logic tick_rise
);

	// main clock cycles per serial half period
	localparam int HALF_DIV = MAIN_CLK_HZ / (2 * SERIAL_CLK_HZ);
	localparam int DIV_BITS = (HALF_DIV > 1) ? $clog2(HALF_DIV) : 1;

	logic [DIV_BITS-1:0] div_ctr;

	// 0: next tick is a fall, 1: next tick is a rise
	logic phase;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			div_ctr <= DIV_BITS'(HALF_DIV - 1);
			phase <= 1'b0;
		end else if (div_ctr == '0) begin
			// reload and flip to the other edge
			div_ctr <= DIV_BITS'(HALF_DIV - 1);
			phase <= ~phase;
		end else begin
			div_ctr <= div_ctr - 1'b1;
		end
	end

	// ticks alternate, fall comes first after reset
	assign tick_fall = (div_ctr == '0) && !phase;
	assign tick_rise = (div_ctr == '0) && phase;

endmodule

// ==== src/serial_cmd.sv ====
`timescale 1ns/10ps

module serial_cmd
	import serial_pkg::*;
#(
	parameter int   BITS                 = 8,
	parameter int   FIFO_DEPTH           = 4,
	parameter logic SERIAL_DATA_INACTIVE = 1'b1
)
(
	input  logic in_clk,
	input  logic in_rst,

	// host transaction strobe
	input  logic in_req,
	input  t_opcode in_op,
	input  logic [BITS-2:0] in_addr,
	input  logic [BITS-1:0] in_data,

	// fill level of the word fifo
	input  logic [$clog2(FIFO_DEPTH):0] fifo_level,

	output logic out_ready,
	output logic out_overflow,

	// word to the fifo, tags on top
	output logic push,
	output logic [BITS+TAG_BITS-1:0] push_word
);

	localparam int LVL_BITS = $clog2(FIFO_DEPTH) + 1;

	// which word of the held transaction is due
	typedef enum logic [1:0] {
		cmd_idle = 2'd0,
		cmd_addr = 2'd1,
		cmd_data = 2'd2
	} t_cmd_state;

	t_cmd_state state;

	// held transaction
	t_opcode req_op;
	logic [BITS-2:0] req_addr;
	logic [BITS-1:0] req_data;

	// fifo words already promised, including the one pending
	logic [LVL_BITS:0] committed;

	assign committed = {1'b0, fifo_level} + ((state == cmd_data) ? 1'b1 : 1'b0);

	// two more words must fit, and the address slot must be free
	assign out_ready = (state != cmd_addr)
		&& (committed <= (LVL_BITS+1)'(FIFO_DEPTH - 2));

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= cmd_idle;
			out_overflow <= 1'b0;
		end else begin
			out_overflow <= in_req && !out_ready;
			if (in_req && out_ready) begin
				state <= cmd_addr;
			end else if (state == cmd_addr) begin
				state <= cmd_data;
			end else if (state == cmd_data) begin
				state <= cmd_idle;
			end
		end
	end

	// latch accepted request
	always_ff @(posedge in_clk) begin
		if (in_req && out_ready) begin
			req_op <= in_op;
			req_addr <= in_addr;
			req_data <= in_data;
		end
	end

	assign push = (state != cmd_idle);

	always_comb begin
		push_word = '0;
		if (state == cmd_addr) begin
			// rw bit above the address, no tags
			push_word[BITS-1] = (req_op == op_read) ? RW_BIT_READ : ~RW_BIT_READ;
			push_word[BITS-2:0] = req_addr;
		end else if (req_op == op_read) begin
			// read: idle data bits, capture the reply
			push_word[BITS-1:0] = {BITS{SERIAL_DATA_INACTIVE}};
			push_word[BITS+TAG_LAST] = 1'b1;
			push_word[BITS+TAG_CAPTURE] = 1'b1;
		end else begin
			push_word[BITS-1:0] = req_data;
			push_word[BITS+TAG_LAST] = 1'b1;
		end
	end

endmodule

// ==== src/word_fifo.sv ====
`timescale 1ns/10ps

module word_fifo
	import serial_pkg::*;
#(
	parameter int BITS       = 8,
	// power of two
	parameter int FIFO_DEPTH = 4
)
(
	input  logic in_clk,
	input  logic in_rst,

	// write side
	input  logic push,
	input  logic [BITS+TAG_BITS-1:0] push_word,

	// read side, head valid while not empty
	input  logic pop,
	output logic [BITS+TAG_BITS-1:0] head_word,
	output logic empty,

	// occupancy, 0 to FIFO_DEPTH
	output logic [$clog2(FIFO_DEPTH):0] level
);

	localparam int WORD_BITS = BITS + TAG_BITS;
	localparam int PTR_BITS  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

	logic [WORD_BITS-1:0] mem [FIFO_DEPTH];

	// pointers wrap on their own since depth is a power of two
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [$clog2(FIFO_DEPTH):0] count;

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			// simultaneous push and pop leave the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge in_clk) begin
		if (push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	assign head_word = mem[rd_ptr];
	assign empty = (count == '0);
	assign level = count;

endmodule

// ==== src/serial.sv ====
`timescale 1ns/10ps

module serial
	import serial_pkg::*;
#(
	// word length
	parameter int   BITS                 = 8,
	parameter logic LOWBIT_FIRST         = 1'b1,

	// idle levels
	parameter logic SERIAL_CLK_INACTIVE  = 1'b1,
	parameter logic SERIAL_DATA_INACTIVE = 1'b1,

	// idle serial periods after a transaction
	parameter int   GAP_BITS             = 2
)
(
	input  logic in_clk,
	input  logic in_rst,

	// edge enables from clkgen
	input  logic tick_fall,
	input  logic tick_rise,

	// word fifo head
	input  logic [BITS+TAG_BITS-1:0] head_word,
	input  logic empty,
	output logic pop,

	// 3-wire side
	output logic out_clk,
	output logic out_serial,
	input  logic in_serial,

	// read data to the host
	output logic [BITS-1:0] out_rd_data,
	output logic out_rd_valid,
	output logic out_busy
);

	localparam int CTR_BITS     = (BITS > 1) ? $clog2(BITS) : 1;
	localparam int GAP_CTR_BITS = (GAP_BITS > 1) ? $clog2(GAP_BITS) : 1;

	t_serial_state state;

	// bit counter and its ordered index
	logic [CTR_BITS-1:0] bit_ctr;
	logic [CTR_BITS-1:0] actual_bit;
	logic bit_done;

	logic [GAP_CTR_BITS-1:0] gap_ctr;

	// shift data, loaded at pop
	logic [BITS-1:0] tx_reg;
	logic [TAG_BITS-1:0] tx_tags;

	// receive data
	logic [BITS-1:0] rx_reg;
	logic [BITS-1:0] rx_next;

	// high between tick_fall and tick_rise
	logic clk_act;

	logic start_word;

	generate
		if (LOWBIT_FIRST) begin : g_low_first
			assign actual_bit = bit_ctr;
		end else begin : g_high_first
			assign actual_bit = CTR_BITS'(BITS - 1) - bit_ctr;
		end
	endgenerate

	assign bit_done = (bit_ctr == CTR_BITS'(BITS - 1));

	// take a word at a fall edge when one is waiting
	always_comb begin
		start_word = 1'b0;
		if (tick_fall && !empty) begin
			case (state)
				Ready: start_word = 1'b1;
				// next word of the same transaction follows directly
				Transmit: start_word = bit_done && !tx_tags[TAG_LAST];
				Gap: start_word = (gap_ctr == '0);
				default: start_word = 1'b0;
			endcase
		end
	end

	assign pop = start_word;

	// received bit merged into the shift register
	always_comb begin
		rx_next = rx_reg;
		rx_next[actual_bit] = in_serial;
	end

	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= Ready;
			bit_ctr <= '0;
			gap_ctr <= '0;
			clk_act <= 1'b0;
			out_rd_valid <= 1'b0;
		end else begin
			out_rd_valid <= 1'b0;

			// serial clock phase
			if (tick_fall) begin
				clk_act <= 1'b1;
			end else if (tick_rise) begin
				clk_act <= 1'b0;
			end

			if (start_word) begin
				state <= Transmit;
				bit_ctr <= '0;
			end else if (tick_fall) begin
				case (state)
					Transmit: begin
						if (!bit_done) begin
							bit_ctr <= bit_ctr + 1'b1;
						end else if (tx_tags[TAG_LAST]) begin
							// end of transaction, hold the lines idle
							state <= Gap;
							gap_ctr <= GAP_CTR_BITS'(GAP_BITS - 1);
						end else begin
							// fifo ran dry mid transaction
							state <= Ready;
						end
					end
					Gap: begin
						if (gap_ctr == '0) begin
							state <= Ready;
						end else begin
							gap_ctr <= gap_ctr - 1'b1;
						end
					end
					default: state <= Ready;
				endcase
			end

			// last sample of a read word
			if (tick_rise && state == Transmit && bit_done && tx_tags[TAG_CAPTURE]) begin
				out_rd_valid <= 1'b1;
			end
		end
	end

	// data path
	always_ff @(posedge in_clk) begin
		if (start_word) begin
			tx_reg <= head_word[BITS-1:0];
			tx_tags <= head_word[BITS +: TAG_BITS];
		end
		if (tick_rise && state == Transmit) begin
			rx_reg <= rx_next;
			if (bit_done && tx_tags[TAG_CAPTURE]) begin
				out_rd_data <= rx_next;
			end
		end
	end

	// clock only toggles while shifting
	assign out_clk = (state == Transmit && clk_act) ? ~SERIAL_CLK_INACTIVE : SERIAL_CLK_INACTIVE;
	assign out_serial = (state == Transmit) ? tx_reg[actual_bit] : SERIAL_DATA_INACTIVE;

	assign out_busy = (state != Ready) || !empty;

endmodule

// ==== src/serial_top.sv ====
`timescale 1ns/10ps

module serial_top
	import serial_pkg::*;
#(
	parameter int   MAIN_CLK_HZ          = 10_000_000,
	parameter int   SERIAL_CLK_HZ        = 1_250_000,
	parameter int   BITS                 = 8,
	parameter logic LOWBIT_FIRST         = 1'b1,
	parameter logic SERIAL_CLK_INACTIVE  = 1'b1,
	parameter logic SERIAL_DATA_INACTIVE = 1'b1,
	parameter int   FIFO_DEPTH           = 4,
	parameter int   GAP_BITS             = 2
)
(
	input  logic in_clk,
	input  logic in_rst,

	// host side
	input  logic in_req,
	input  t_opcode in_op,
	input  logic [BITS-2:0] in_addr,
	input  logic [BITS-1:0] in_data,
	output logic out_ready,
	output logic out_overflow,

	// 3-wire side
	output logic out_clk,
	output logic out_serial,
	input  logic in_serial,

	// read return
	output logic [BITS-1:0] out_rd_data,
	output logic out_rd_valid,
	output logic out_busy
);

	logic tick_fall;
	logic tick_rise;
	logic push;
	logic [BITS+TAG_BITS-1:0] push_word;
	logic pop;
	logic [BITS+TAG_BITS-1:0] head_word;
	logic empty;
	logic [$clog2(FIFO_DEPTH):0] fifo_level;

	clkgen #(
		.MAIN_CLK_HZ(MAIN_CLK_HZ), .SERIAL_CLK_HZ(SERIAL_CLK_HZ)
	) u_clkgen (
		.in_clk(in_clk), .in_rst(in_rst),
		.tick_fall(tick_fall), .tick_rise(tick_rise)
	);

	serial_cmd #(
		.BITS(BITS), .FIFO_DEPTH(FIFO_DEPTH), .SERIAL_DATA_INACTIVE(SERIAL_DATA_INACTIVE)
	) u_serial_cmd (
		.in_clk(in_clk), .in_rst(in_rst),
		.in_req(in_req), .in_op(in_op), .in_addr(in_addr), .in_data(in_data),
		.fifo_level(fifo_level),
		.out_ready(out_ready), .out_overflow(out_overflow),
		.push(push), .push_word(push_word)
	);

	word_fifo #(
		.BITS(BITS), .FIFO_DEPTH(FIFO_DEPTH)
	) u_word_fifo (
		.in_clk(in_clk), .in_rst(in_rst),
		.push(push), .push_word(push_word),
		.pop(pop), .head_word(head_word), .empty(empty),
		.level(fifo_level)
	);

	serial #(
		.BITS(BITS), .LOWBIT_FIRST(LOWBIT_FIRST),
		.SERIAL_CLK_INACTIVE(SERIAL_CLK_INACTIVE),
		.SERIAL_DATA_INACTIVE(SERIAL_DATA_INACTIVE),
		.GAP_BITS(GAP_BITS)
	) u_serial (
		.in_clk(in_clk), .in_rst(in_rst),
		.tick_fall(tick_fall), .tick_rise(tick_rise),
		.head_word(head_word), .empty(empty), .pop(pop),
		.out_clk(out_clk), .out_serial(out_serial), .in_serial(in_serial),
		.out_rd_data(out_rd_data), .out_rd_valid(out_rd_valid), .out_busy(out_busy)
	);

endmodule

// ==== testbench/serial_chk.sv ====
`timescale 1ns/10ps

module serial_chk
	import serial_pkg::*;
#(
	parameter int   FIFO_DEPTH          = 4,
	parameter logic SERIAL_CLK_INACTIVE = 1'b1
)
(
	input logic in_clk,
	input logic in_rst,

	// word fifo side
	input logic push,
	input logic pop,
	input logic empty,
	input logic [$clog2(FIFO_DEPTH):0] fifo_level,

	// serial engine side
	input t_serial_state state,
	input logic out_clk,
	input logic out_rd_valid
);

	// read strobe is a single pulse
	a_rd_pulse: assert property (@(posedge in_clk) disable iff (in_rst)
		out_rd_valid |=> !out_rd_valid)
		else $error("out_rd_valid held for more than one cycle");

	// engine never takes from an empty fifo
	a_no_underflow: assert property (@(posedge in_clk) disable iff (in_rst)
		pop |-> !empty)
		else $error("pop while the word fifo is empty");

	// builder never writes into a full fifo
	a_no_overrun: assert property (@(posedge in_clk) disable iff (in_rst)
		push |-> (fifo_level != FIFO_DEPTH))
		else $error("push while the word fifo is full");

	// serial clock parked outside a word
	a_clk_idle: assert property (@(posedge in_clk) disable iff (in_rst)
		(state == Ready || state == Gap) |-> (out_clk == SERIAL_CLK_INACTIVE))
		else $error("out_clk active while the engine is idle");

endmodule

// sits over the engine and the fifo together
bind serial_top serial_chk #(
	.FIFO_DEPTH(FIFO_DEPTH), .SERIAL_CLK_INACTIVE(SERIAL_CLK_INACTIVE)
) u_serial_chk (
	.in_clk(in_clk), .in_rst(in_rst),
	.push(push), .pop(pop), .empty(empty), .fifo_level(fifo_level),
	.state(u_serial.state), .out_clk(out_clk), .out_rd_valid(out_rd_valid)
);

// ==== testbench/serial_tb.sv ====
`timescale 1ns/10ps

module serial_tb
	import serial_pkg::*;
();

	localparam int   CLK_PERIOD    = 100;
	localparam int   DRIVE_DLY     = 10;
	// half divide of 4, so 8 main cycles per serial bit
	localparam int   SER_PERIOD    = 8 * CLK_PERIOD;
	localparam logic CLK_INACTIVE  = 1'b1;
	localparam logic DATA_INACTIVE = 1'b1;
	localparam int   NUM_TESTS     = 14;
	localparam int   IDLE_LIMIT    = 2 * 20 * 8;
	localparam int   WATCHDOG_NS   = NUM_TESTS * 20 * SER_PERIOD + 100 * CLK_PERIOD;

	typedef enum logic [1:0] {m_single, m_pair, m_drop} t_mode;

	typedef struct {
		t_mode mode;
		t_opcode op;
		logic [6:0] addr;
		logic [7:0] data;
		logic [7:0] exp;
		logic dropped;
	} t_entry;

	// one transaction as the peripheral saw it
	typedef struct {
		logic rw;
		logic [6:0] addr;
		logic [7:0] data;
	} t_xfer;

	logic in_clk, in_rst, in_req, in_serial;
	t_opcode in_op;
	logic [6:0] in_addr;
	logic [7:0] in_data, out_rd_data;
	logic out_ready, out_overflow, out_clk, out_serial, out_rd_valid, out_busy;

	t_entry tests [NUM_TESTS];
	logic [7:0] model_regs [128];
	logic [7:0] periph_regs [128];
	logic [31:0] rng;
	t_xfer seen_q [$];
	logic [7:0] rd_q [$];
	logic [15:0] shift_in;
	int bit_cnt;
	time last_rise;
	int err_count;

	serial_top #(
		.MAIN_CLK_HZ(10_000_000), .SERIAL_CLK_HZ(1_250_000), .BITS(8), .LOWBIT_FIRST(1'b1),
		.SERIAL_CLK_INACTIVE(CLK_INACTIVE), .SERIAL_DATA_INACTIVE(DATA_INACTIVE),
		.FIFO_DEPTH(4), .GAP_BITS(2)
	) u_serial_top (
		.in_clk(in_clk), .in_rst(in_rst), .in_req(in_req), .in_op(in_op),
		.in_addr(in_addr), .in_data(in_data), .out_ready(out_ready),
		.out_overflow(out_overflow), .out_clk(out_clk), .out_serial(out_serial),
		.in_serial(in_serial), .out_rd_data(out_rd_data), .out_rd_valid(out_rd_valid),
		.out_busy(out_busy)
	);

	initial begin
		in_clk = 1'b0;
		forever #(CLK_PERIOD / 2) in_clk = ~in_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// power-up contents depend on every address bit, never the idle pattern
	function automatic logic [7:0] fill_value(input logic [6:0] a);
		return {a[3:0], a[6:4], ~^a};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("Fail at %0t ns: %s got %0h expected %0h", $time, name, got, want);
			err_count++;
		end
	endtask

	task automatic flag_problem(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		err_count++;
	endtask

	task automatic step();
		@(posedge in_clk);
		#DRIVE_DLY;
	endtask

	task automatic set_entry(input int idx, input t_mode mode, input t_opcode op,
		input logic [6:0] addr);
		rng = xorshift32(rng);
		tests[idx] = '{mode, op, addr, rng[7:0], 8'h00, 1'b0};
	endtask

	task automatic send(input t_entry e);
		in_req = 1'b1;
		in_op = e.op;
		in_addr = e.addr;
		in_data = e.data;
		step();
		in_req = 1'b0;
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!out_ready && n < IDLE_LIMIT) begin
			step();
			n++;
		end
		if (!out_ready) begin
			flag_problem("out_ready never came back");
		end
	endtask

	// busy rises once the words land in the fifo, falls after the gap
	task automatic wait_idle();
		int n;
		n = 0;
		while (!out_busy && n < 10) begin
			step();
			n++;
		end
		if (!out_busy) begin
			flag_problem("out_busy never rose after a request");
		end
		n = 0;
		while (out_busy && n < IDLE_LIMIT) begin
			step();
			n++;
		end
		if (out_busy) begin
			flag_problem("out_busy stuck high");
		end
	endtask

	task automatic check_entry(input t_entry e);
		t_xfer x;
		logic want_rw;
		// read sends a one on top of the address, write a zero
		want_rw = (e.op == op_read) ? 1'b1 : 1'b0;
		if (e.dropped) begin
			return;
		end
		if (seen_q.size() == 0) begin
			flag_problem("transaction never reached the peripheral");
			return;
		end
		x = seen_q.pop_front();
		if (x.rw !== want_rw) begin
			flag_problem("peripheral saw the wrong read/write bit");
		end
		check_value("periph addr", x.addr, e.addr);
		if (e.op == op_write) begin
			check_value("periph data", x.data, e.data);
		end else begin
			// data word of a read shifts idle bits out
			check_value("periph data", x.data, {8{DATA_INACTIVE}});
			if (rd_q.size() == 0) begin
				flag_problem("read finished without out_rd_valid");
			end else begin
				check_value("out_rd_data", rd_q.pop_front(), e.exp);
			end
		end
	endtask

	// peripheral samples where out_clk returns to its idle level
	always @(posedge out_clk) begin
		t_xfer x;
		if (!in_rst) begin
			shift_in[bit_cnt] = out_serial;
			last_rise = $time;
			if (bit_cnt == 15) begin
				x.rw = shift_in[7];
				x.addr = shift_in[6:0];
				x.data = shift_in[15:8];
				if (x.rw != RW_BIT_READ) begin
					periph_regs[x.addr] = x.data;
				end
				seen_q.push_back(x);
				bit_cnt = 0;
			end else begin
				bit_cnt++;
			end
		end
	end

	// reply bits go out on the opposite edge
	always @(negedge out_clk) begin
		if (!in_rst) begin
			if (bit_cnt != 0 && ($time - last_rise) > SER_PERIOD) begin
				flag_problem("serial clock paused in the middle of a transaction");
				bit_cnt = 0;
			end
			if (bit_cnt >= 8 && shift_in[7] == RW_BIT_READ) begin
				in_serial <= periph_regs[shift_in[6:0]][bit_cnt-8];
			end else begin
				in_serial <= DATA_INACTIVE;
			end
		end
	end

	// read returns in arrival order
	always @(negedge in_clk) begin
		if (out_rd_valid) begin
			rd_q.push_back(out_rd_data);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Error at %0t ns: watchdog expired before the table finished", $time);
		$display("test failed");
		$finish;
	end

	initial begin
		int i;
		int n;
		int errs_before;
		int n_run;
		int n_bad;
		in_rst = 1'b1;
		in_req = 1'b0;
		in_op = op_write;
		in_addr = '0;
		in_data = '0;
		in_serial = DATA_INACTIVE;
		bit_cnt = 0;
		last_rise = 0;
		err_count = 0;
		n_run = 0;
		n_bad = 0;
		rng = 32'd89684;
		for (int a = 0; a < 128; a++) begin
			model_regs[a] = fill_value(7'(a));
			periph_regs[a] = fill_value(7'(a));
		end

		// pairs and drops consume the following entry too
		set_entry(0, m_single, op_write, 7'h05);
		set_entry(1, m_single, op_read, 7'h05);
		set_entry(2, m_single, op_read, 7'h7F);
		set_entry(3, m_single, op_write, 7'h7F);
		set_entry(4, m_pair, op_write, 7'h10);
		set_entry(5, m_single, op_write, 7'h11);
		set_entry(6, m_pair, op_read, 7'h7F);
		set_entry(7, m_single, op_read, 7'h10);
		set_entry(8, m_drop, op_write, 7'h22);
		set_entry(9, m_single, op_write, 7'h11);
		set_entry(10, m_single, op_read, 7'h11);
		set_entry(11, m_single, op_read, 7'h22);
		set_entry(12, m_pair, op_write, 7'h33);
		set_entry(13, m_single, op_read, 7'h33);

		// expected reads from the table's own surviving writes
		for (int k = 0; k < NUM_TESTS; k++) begin
			tests[k].dropped = (k > 0) && (tests[k-1].mode == m_drop);
			if (!tests[k].dropped && tests[k].op == op_write) begin
				model_regs[tests[k].addr] = tests[k].data;
			end else if (!tests[k].dropped) begin
				tests[k].exp = model_regs[tests[k].addr];
			end
		end

		repeat (2) @(posedge in_clk);
		#DRIVE_DLY;
		in_rst = 1'b0;

		// idle levels straight out of reset
		check_value("out_ready", out_ready, 1'b1);
		check_value("out_busy", out_busy, 1'b0);
		check_value("out_rd_valid", out_rd_valid, 1'b0);
		check_value("out_overflow", out_overflow, 1'b0);
		check_value("out_clk", out_clk, CLK_INACTIVE);
		check_value("out_serial", out_serial, DATA_INACTIVE);
		n_run++;
		n_bad += (err_count != 0);
		$display("test reset: %s", (err_count == 0) ? "ok" : "FAIL");

		i = 0;
		while (i < NUM_TESTS) begin
			errs_before = err_count;
			n = (tests[i].mode == m_single) ? 1 : 2;
			wait_ready();
			send(tests[i]);
			if (tests[i].mode == m_pair) begin
				// second request as soon as there is room
				wait_ready();
				send(tests[i+1]);
			end else if (tests[i].mode == m_drop) begin
				// address word still pending
				check_value("out_ready", out_ready, 1'b0);
				send(tests[i+1]);
				check_value("out_overflow", out_overflow, 1'b1);
				step();
				check_value("out_overflow", out_overflow, 1'b0);
			end
			wait_idle();

			// busy fell, so everything sent must be complete
			check_value("transactions seen", seen_q.size(), (tests[i].mode == m_pair) ? 2 : 1);
			for (int k = i; k < i + n; k++) begin
				check_entry(tests[k]);
			end
			if (seen_q.size() != 0) begin
				flag_problem("peripheral saw a transaction that was not sent");
				seen_q.delete();
			end
			if (rd_q.size() != 0) begin
				flag_problem("out_rd_valid without a pending read");
				rd_q.delete();
			end
			if (bit_cnt != 0) begin
				flag_problem("peripheral left with an unfinished transaction");
				bit_cnt = 0;
			end

			n_run++;
			n_bad += (err_count != errs_before);
			$display("test %0d %s %s addr %0h: %s", i, tests[i].mode.name(),
				tests[i].op.name(), tests[i].addr, (err_count == errs_before) ? "ok" : "FAIL");
			i += n;
		end

		$display("%0d tests run, %0d ok, %0d bad, %0d errors", n_run, n_run - n_bad, n_bad,
			err_count);
		if (err_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
src/serial_pkg.sv
src/clkgen.sv
src/serial_cmd.sv
src/word_fifo.sv
src/serial.sv
src/serial_top.sv
testbench/serial_chk.sv
testbench/serial_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= serial_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= test failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@status=0; ./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
